//--- flist.f
mem_bus_pkg.sv
mem_bus_if.sv
mem_addr_decoder.sv
mem_interconnect.sv
prog_ram.sv
periph_regs.sv
soc_mem_top.sv
tb_soc_mem_props.sv
tb_soc_mem.sv

//--- mem_addr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module mem_addr_decoder
   import mem_bus_pkg::*;
(
   input  addr_t      addr,
   output slave_sel_t slave_sel,
   output logic       unmapped
);

   region_t region;
   logic    ram_high;
   logic    periph_high;

   // Region field on top of the address
   assign region = addr[region_msb:region_lsb];

   // Offset bits beyond each slave's window
   assign ram_high    = |addr[region_lsb-1:ram_idx_msb+1];
   assign periph_high = |addr[region_lsb-1:periph_idx_msb+1];

   always_comb begin
      // Default is unmapped, no slave
      slave_sel = '0;
      unmapped  = 1'b1;
      case (region)
         region_ram: begin
            if (!ram_high) begin
               slave_sel[sel_ram] = 1'b1;
               unmapped           = 1'b0;
            end
         end
         region_periph: begin
            if (!periph_high) begin
               slave_sel[sel_periph] = 1'b1;
               unmapped              = 1'b0;
            end
         end
         // Regions 2 and 3 stay unmapped
         default: begin
            slave_sel = '0;
            unmapped  = 1'b1;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if import mem_bus_pkg::*; ();

   // Request side, driven by the master
   logic  valid;
   addr_t addr;
   data_t wdata;
   strb_t wstrb;

   // Response side, driven by the slave
   data_t rdata;
   logic  ready;

   modport master (
      output valid, addr, wdata, wstrb,
      input  rdata, ready
   );

   modport slave (
      input  valid, addr, wdata, wstrb,
      output rdata, ready
   );

endinterface

`default_nettype wire

//--- mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Bus widths
   ////////////////////////////////////////////////////////////////////////////
   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;
   // All-zero strobe marks a read
   typedef logic [3:0]  strb_t;
   typedef logic [7:0]  gpio_t;

   // Real slaves, one-hot select
   localparam int n_slaves   = 2;
   localparam int sel_ram    = 0;
   localparam int sel_periph = 1;
   typedef logic [n_slaves-1:0] slave_sel_t;

   ////////////////////////////////////////////////////////////////////////////
   // Memory map
   ////////////////////////////////////////////////////////////////////////////
   localparam int region_msb = 31;
   localparam int region_lsb = 30;
   typedef logic [region_msb-region_lsb:0] region_t;
   localparam region_t region_ram    = 2'd0;
   localparam region_t region_periph = 2'd1;

   // Program RAM, 1 KiB of words
   localparam int ram_words   = 256;
   localparam int ram_idx_lsb = 2;
   localparam int ram_idx_msb = ram_idx_lsb + $clog2(ram_words) - 1;
   typedef logic [$clog2(ram_words)-1:0] ram_idx_t;

   // Peripheral register offsets
   localparam int periph_idx_lsb = 2;
   localparam int periph_idx_msb = 3;
   typedef logic [periph_idx_msb-periph_idx_lsb:0] periph_idx_t;
   localparam periph_idx_t reg_scratch0 = 2'd0;
   localparam periph_idx_t reg_scratch1 = 2'd1;
   localparam periph_idx_t reg_gpio_out = 2'd2;
   localparam periph_idx_t reg_gpio_in  = 2'd3;

   // Answer for unmapped reads
   localparam data_t bad_rdata = 32'hdead_beef;

   // Byte-strobe merge of new data over an old word
   function automatic data_t merge_strb(data_t old_word, data_t new_word, strb_t strb);
      data_t result;
      result = old_word;
      for (int b = 0; b < $bits(strb_t); b++) begin
         if (strb[b]) begin
            result[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return result;
   endfunction

endpackage

`default_nettype wire

//--- mem_interconnect.sv
`timescale 1ns/1ps
`default_nettype none

module mem_interconnect
   import mem_bus_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   mem_bus_if.slave  m,
   mem_bus_if.master s_ram,
   mem_bus_if.master s_periph
);

   slave_sel_t slave_sel;
   logic       unmapped;
   logic       bad_ready;

   // Address decode, purely combinational
   mem_addr_decoder u_dec (
      .addr      (m.addr),
      .slave_sel (slave_sel),
      .unmapped  (unmapped)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Request fan-out
   ////////////////////////////////////////////////////////////////////////////
   assign s_ram.addr     = m.addr;
   assign s_ram.wdata    = m.wdata;
   assign s_ram.wstrb    = m.wstrb;
   assign s_periph.addr  = m.addr;
   assign s_periph.wdata = m.wdata;
   assign s_periph.wstrb = m.wstrb;

   // Valid only toward the selected slave
   assign s_ram.valid    = m.valid & slave_sel[sel_ram];
   assign s_periph.valid = m.valid & slave_sel[sel_periph];

   // Unmapped responder, one-cycle ready pulse
   // Write data goes nowhere
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bad_ready <= 1'b0;
      end else begin
         bad_ready <= m.valid & unmapped & ~bad_ready;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Response mux
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      m.ready = bad_ready;
      m.rdata = bad_rdata;
      if (slave_sel[sel_ram]) begin
         m.ready = s_ram.ready;
         m.rdata = s_ram.rdata;
      end else if (slave_sel[sel_periph]) begin
         m.ready = s_periph.ready;
         m.rdata = s_periph.rdata;
      end
   end

endmodule

`default_nettype wire

//--- periph_regs.sv
`timescale 1ns/1ps
`default_nettype none

module periph_regs
   import mem_bus_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   mem_bus_if.slave bus,
   input  gpio_t    gpio_in,
   output gpio_t    gpio_out
);

   periph_idx_t idx;
   logic        access;
   data_t       scratch0;
   data_t       scratch1;
   gpio_t       gpio_meta;
   gpio_t       gpio_sync;
   data_t       rd_word;

   assign idx    = bus.addr[periph_idx_msb:periph_idx_lsb];
   assign access = bus.valid & ~bus.ready;

   // Two-flop synchronizer on the input pins
   always_ff @(posedge clk) begin
      gpio_meta <= gpio_in;
      gpio_sync <= gpio_meta;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Register writes and ready
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bus.ready <= 1'b0;
         scratch0  <= '0;
         scratch1  <= '0;
         gpio_out  <= '0;
      end else begin
         bus.ready <= access;
         if (access) begin
            case (idx)
               reg_scratch0: scratch0 <= merge_strb(scratch0, bus.wdata, bus.wstrb);
               reg_scratch1: scratch1 <= merge_strb(scratch1, bus.wdata, bus.wstrb);
               // Byte 0 only
               reg_gpio_out: if (bus.wstrb[0]) gpio_out <= bus.wdata[7:0];
               // gpio_in is read-only
               default: ;
            endcase
         end
      end
   end

   // Read mux, upper GPIO bits read zero
   always_comb begin
      case (idx)
         reg_scratch0: rd_word = scratch0;
         reg_scratch1: rd_word = scratch1;
         reg_gpio_out: rd_word = data_t'(gpio_out);
         reg_gpio_in:  rd_word = data_t'(gpio_sync);
         default:      rd_word = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (access) bus.rdata <= rd_word;
   end

endmodule

`default_nettype wire

//--- prog_ram.sv
`timescale 1ns/1ps
`default_nettype none

module prog_ram
   import mem_bus_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   mem_bus_if.slave bus
);

   data_t    mem [ram_words];
   ram_idx_t idx;
   logic     access;

   // Word index from the byte address
   assign idx = bus.addr[ram_idx_msb:ram_idx_lsb];

   // New request only while no ready is out
   assign access = bus.valid & ~bus.ready;

   ////////////////////////////////////////////////////////////////////////////
   // Handshake
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bus.ready <= 1'b0;
      end else begin
         // Single pulse, one cycle after valid
         bus.ready <= access;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Storage
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (access) begin
         // Strobed bytes only, zero strobe leaves the word alone
         mem[idx] <= merge_strb(mem[idx], bus.wdata, bus.wstrb);
         // Old word, so rdata after a write is not meaningful
         bus.rdata <= mem[idx];
      end
   end

endmodule

`default_nettype wire

//--- soc_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_mem_top
   import mem_bus_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   // Master bus
   input  logic  m_valid,
   input  addr_t m_addr,
   input  data_t m_wdata,
   input  strb_t m_wstrb,
   output data_t m_rdata,
   output logic  m_ready,
   // GPIO pins
   input  gpio_t gpio_in,
   output gpio_t gpio_out
);

   ////////////////////////////////////////////////////////////////////////////
   // Bus instances
   ////////////////////////////////////////////////////////////////////////////
   mem_bus_if bus_m ();
   mem_bus_if bus_ram ();
   mem_bus_if bus_periph ();

   // Plain ports onto the master bus
   assign bus_m.valid = m_valid;
   assign bus_m.addr  = m_addr;
   assign bus_m.wdata = m_wdata;
   assign bus_m.wstrb = m_wstrb;
   assign m_rdata     = bus_m.rdata;
   assign m_ready     = bus_m.ready;

   mem_interconnect u_xbar (
      .clk      (clk),
      .rst_n    (rst_n),
      .m        (bus_m.slave),
      .s_ram    (bus_ram.master),
      .s_periph (bus_periph.master)
   );

   // Slave 0, program RAM at address zero
   prog_ram u_ram (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (bus_ram.slave)
   );

   // Slave 1, scratch and GPIO
   periph_regs u_periph (
      .clk      (clk),
      .rst_n    (rst_n),
      .bus      (bus_periph.slave),
      .gpio_in  (gpio_in),
      .gpio_out (gpio_out)
   );

endmodule

`default_nettype wire

//--- tb_soc_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_mem import mem_bus_pkg::*; ();

   typedef enum logic [1:0] {op_wr, op_rd, op_pin, op_pins} op_kind_t;

   localparam data_t unmapped_word = 32'hdead_beef;
   localparam int    reset_cycles  = 16;

   logic  clk;
   logic  rst_n;
   logic  m_valid;
   addr_t m_addr;
   data_t m_wdata;
   strb_t m_wstrb;
   data_t m_rdata;
   logic  m_ready;
   gpio_t gpio_in;
   gpio_t gpio_out;

   // Operation table, one slot per column
   op_kind_t tbl_kind [$];
   addr_t    tbl_addr [$];
   data_t    tbl_wdata [$];
   strb_t    tbl_wstrb [$];
   data_t    tbl_exp [$];

   // Expected RAM contents
   data_t  shadow [ram_words];
   integer seed = 32'h92c5_74f8;
   int     pass_cnt = 0;
   int     fail_cnt = 0;
   int     cycle_cnt = 0;
   int     cycle_limit = 1000;

   soc_mem_top dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .m_valid  (m_valid),
      .m_addr   (m_addr),
      .m_wdata  (m_wdata),
      .m_wstrb  (m_wstrb),
      .m_rdata  (m_rdata),
      .m_ready  (m_ready),
      .gpio_in  (gpio_in),
      .gpio_out (gpio_out)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   // Watchdog on total cycles
   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
         $display("timeout: no end of test after %0d cycles", cycle_limit);
         $display("TB FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Reference model and table
   ////////////////////////////////////////////////////////////////////////////

   // Strobe turned into a byte mask
   function automatic data_t strobe_write(data_t old_word, data_t new_word, strb_t strb);
      data_t mask;
      mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
      return (old_word & ~mask) | (new_word & mask);
   endfunction

   task automatic add_op(op_kind_t kind, addr_t addr, data_t wdata, strb_t wstrb, data_t exp);
      tbl_kind.push_back(kind);
      tbl_addr.push_back(addr);
      tbl_wdata.push_back(wdata);
      tbl_wstrb.push_back(wstrb);
      tbl_exp.push_back(exp);
   endtask

   task automatic ram_write_entry(int idx, data_t wdata, strb_t wstrb);
      add_op(op_wr, addr_t'(idx * 4), wdata, wstrb, '0);
      shadow[idx] = strobe_write(shadow[idx], wdata, wstrb);
   endtask

   task automatic ram_read_entry(int idx);
      add_op(op_rd, addr_t'(idx * 4), '0, 4'h0, shadow[idx]);
   endtask

   task automatic build_table();
      int ram_idx [5];
      ram_idx = '{0, 1, 17, 128, 255};
      // Peripheral block straight out of reset
      add_op(op_rd, 32'h4000_0000, '0, 4'h0, 32'h0);
      add_op(op_rd, 32'h4000_0004, '0, 4'h0, 32'h0);
      add_op(op_rd, 32'h4000_0008, '0, 4'h0, 32'h0);
      add_op(op_pins, '0, '0, 4'h0, 32'h0);
      // Full words incl. first and last index
      foreach (ram_idx[k]) ram_write_entry(ram_idx[k], $random(seed), 4'hf);
      foreach (ram_idx[k]) ram_read_entry(ram_idx[k]);
      // Partial strobes over known words
      ram_write_entry(17, $random(seed), 4'b0101);
      ram_read_entry(17);
      ram_write_entry(128, $random(seed), 4'b1000);
      ram_read_entry(128);
      ram_write_entry(0, $random(seed), 4'b0110);
      ram_read_entry(0);
      // Scratch and GPIO
      add_op(op_wr, 32'h4000_0004, 32'h1234_5678, 4'hf, '0);
      add_op(op_rd, 32'h4000_0004, '0, 4'h0, 32'h1234_5678);
      add_op(op_wr, 32'h4000_0008, 32'ha5c3_1e5a, 4'hf, '0);
      add_op(op_pins, '0, '0, 4'h0, 32'h0000_005a);
      add_op(op_rd, 32'h4000_0008, '0, 4'h0, 32'h0000_005a);
      add_op(op_pin, '0, 32'h0000_003c, 4'h0, '0);
      add_op(op_rd, 32'h4000_000c, '0, 4'h0, 32'h0000_003c);
      // gpio_in ignores writes
      add_op(op_wr, 32'h4000_000c, 32'hffff_ffff, 4'hf, '0);
      add_op(op_rd, 32'h4000_000c, '0, 4'h0, 32'h0000_003c);
      // Other registers untouched by that write
      add_op(op_pins, '0, '0, 4'h0, 32'h0000_005a);
      add_op(op_rd, 32'h4000_0000, '0, 4'h0, 32'h0);
      // Unmapped reads
      add_op(op_rd, 32'h8000_0000, '0, 4'h0, unmapped_word);
      add_op(op_rd, 32'hc000_0010, '0, 4'h0, unmapped_word);
      add_op(op_rd, 32'h0000_0400, '0, 4'h0, unmapped_word);
      add_op(op_rd, 32'h4000_0010, '0, 4'h0, unmapped_word);
      // Alias of word 17 above 1 KiB, then region 2 alias of word 0
      add_op(op_wr, 32'h0000_0444, 32'h0bad_0bad, 4'hf, '0);
      ram_read_entry(17);
      add_op(op_wr, 32'h8000_0000, 32'h0bad_0bad, 4'hf, '0);
      ram_read_entry(0);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////////////////////
   task automatic check_data(string name, data_t exp, data_t act);
      if (act === exp) begin
         pass_cnt++;
         $display("ok    %s = 0x%08h", name, act);
      end else begin
         fail_cnt++;
         $display("error %s expected 0x%08h got 0x%08h", name, exp, act);
      end
   endtask

   task automatic check_gpio(string name, gpio_t exp, gpio_t act);
      if (act === exp) begin
         pass_cnt++;
         $display("ok    %s = 0x%02h", name, act);
      end else begin
         fail_cnt++;
         $display("error %s expected 0x%02h got 0x%02h", name, exp, act);
      end
   endtask

   task automatic check_latency(string name, int exp, int act);
      if (act == exp) begin
         pass_cnt++;
         $display("ok    %s = 0x%0h cycles", name, act);
      end else begin
         fail_cnt++;
         $display("error %s expected 0x%0h got 0x%0h cycles", name, exp, act);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Table steps, each entered 2 ns after a rising edge
   ////////////////////////////////////////////////////////////////////////////
   task automatic run_bus_op(int i);
      int    lat;
      logic  rdy;
      data_t rd;
      m_valid = 1'b1;
      m_addr  = tbl_addr[i];
      m_wdata = tbl_wdata[i];
      m_wstrb = tbl_wstrb[i];
      // Edge that samples valid
      @(posedge clk);
      lat = 0;
      rdy = 1'b0;
      while (!rdy) begin
         @(negedge clk);
         rdy = m_ready;
         rd  = m_rdata;
         @(posedge clk);
         lat++;
      end
      #2;
      m_valid = 1'b0;
      m_wstrb = '0;
      check_latency($sformatf("m_ready latency op %0d", i), 1, lat);
      if (tbl_kind[i] == op_rd) begin
         check_data($sformatf("m_rdata op %0d", i), tbl_exp[i], rd);
      end
      // Idle cycle between requests
      @(posedge clk);
      #2;
   endtask

   task automatic apply_gpio_in(int i);
      gpio_in = tbl_wdata[i][7:0];
      // Two synchronizer flops
      repeat (2) @(posedge clk);
      #2;
   endtask

   task automatic sample_gpio_out(int i);
      @(negedge clk);
      check_gpio($sformatf("gpio_out op %0d", i), tbl_exp[i][7:0], gpio_out);
      @(posedge clk);
      #2;
   endtask

   initial begin
      rst_n   = 1'b0;
      m_valid = 1'b0;
      m_addr  = '0;
      m_wdata = '0;
      m_wstrb = '0;
      gpio_in = '0;
      build_table();
      cycle_limit = tbl_kind.size() * 4 + reset_cycles + 50;
      repeat (reset_cycles) @(posedge clk);
      #2;
      rst_n = 1'b1;
      @(posedge clk);
      #2;
      for (int i = 0; i < tbl_kind.size(); i++) begin
         case (tbl_kind[i])
            op_pin:  apply_gpio_in(i);
            op_pins: sample_gpio_out(i);
            default: run_bus_op(i);
         endcase
      end
      $display("checks: %0d passed, %0d failed, %0d assertion failures",
               pass_cnt, fail_cnt, dut.u_xbar.u_props.assert_fails);
      if (fail_cnt == 0 && dut.u_xbar.u_props.assert_fails == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tb_soc_mem_props.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_mem_props
   import mem_bus_pkg::*;
(
   input logic  clk,
   input logic  rst_n,
   input logic  m_valid,
   input addr_t m_addr,
   input logic  m_ready,
   input logic  ram_valid,
   input logic  periph_valid
);

   // Count of failed assertions
   int assert_fails = 0;

   // Never two slaves addressed at once
   a_one_slave: assert property (@(posedge clk) disable iff (!rst_n)
      !(ram_valid && periph_valid))
      else begin
         assert_fails = assert_fails + 1;
         $error("both slave valids high");
      end

   // No response without a request
   a_ready_valid: assert property (@(posedge clk) disable iff (!rst_n)
      m_ready |-> m_valid)
      else begin
         assert_fails = assert_fails + 1;
         $error("m_ready high without m_valid");
      end

   // Request held until ready
   a_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (m_valid && !m_ready) |=> (m_valid && $stable(m_addr)))
      else begin
         assert_fails = assert_fails + 1;
         $error("request dropped or changed before ready");
      end

   // Single-cycle ready pulse
   a_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      m_ready |=> !m_ready)
      else begin
         assert_fails = assert_fails + 1;
         $error("m_ready high for two cycles");
      end

endmodule

bind mem_interconnect tb_soc_mem_props u_props (
   .clk          (clk),
   .rst_n        (rst_n),
   .m_valid      (m.valid),
   .m_addr       (m.addr),
   .m_ready      (m.ready),
   .ram_valid    (s_ram.valid),
   .periph_valid (s_periph.valid)
);

`default_nettype wire
